// ==== sfm_acc_pkg.sv ====
/*
 * Shared definitions for the softmax denominator unit
 * Fixed-point widths and formats, word types and the phase encoding
 */

package sfm_acc_pkg;

    // Addends and factors are unsigned Q1.15
    localparam int unsigned ADD_W    = 16;
    localparam int unsigned ADD_FRAC = 15;

    // Partial sums, denominator and reciprocal are unsigned Q8.16
    localparam int unsigned ACC_W    = 24;
    localparam int unsigned ACC_FRAC = 16;

    typedef logic [ADD_W-1:0] addend_t;
    typedef logic [ACC_W-1:0] acc_t;

    // 2.0 in Q8.16, used by the Newton step
    localparam acc_t ACC_TWO = acc_t'(2) << ACC_FRAC;

    typedef enum logic [2:0] {
        IDLE,
        COMPUTING,
        REDUCTION,
        INVERSION,
        FINISHED
    } acc_state_e;

endpackage

// ==== sfm_lane_dispatch.sv ====
/*
 * Input dispatcher: ready gating, addend alignment to Q8.16
 * and round-robin lane selection for accepted addends
 */

`timescale 1ns/1ps

module sfm_lane_dispatch import sfm_acc_pkg::*; #(
    parameter int unsigned N_LANES = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               clear_i,
    input  logic               accept_en_i,
    input  logic               add_valid_i,
    input  addend_t            add_i,
    input  logic               mul_valid_i,
    input  addend_t            mul_i,
    output logic               ready_o,
    output logic [N_LANES-1:0] add_en_o,
    output logic               scale_en_o,
    output acc_t               addend_o,
    output addend_t            factor_o
);

    localparam int unsigned LANE_W = $clog2(N_LANES);

    logic              add_take;
    logic              mul_take;
    logic [LANE_W-1:0] lane_ptr_q;

    assign ready_o  = accept_en_i;
    assign add_take = accept_en_i & add_valid_i;
    assign mul_take = accept_en_i & mul_valid_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lane_ptr_q <= '0;
            add_en_o   <= '0;
            scale_en_o <= 1'b0;
        end else if (clear_i) begin
            lane_ptr_q <= '0;
            add_en_o   <= '0;
            scale_en_o <= 1'b0;
        end else begin
            add_en_o   <= add_take ? (N_LANES'(1) << lane_ptr_q) : '0;
            scale_en_o <= mul_take;
            if (add_take) begin
                if (lane_ptr_q == LANE_W'(N_LANES - 1)) begin
                    lane_ptr_q <= '0;
                end else begin
                    lane_ptr_q <= lane_ptr_q + 1'b1;
                end
            end
        end
    end

    // Q1.15 to Q8.16
    always_ff @(posedge clk_i) begin
        addend_o <= acc_t'(add_i) << (ACC_FRAC - ADD_FRAC);
        factor_o <= mul_i;
    end

endmodule

// ==== sfm_acc_lane.sv ====
/*
 * One partial-sum lane
 * Rescales the held sum by a Q1.15 factor and adds an aligned addend
 */

`timescale 1ns/1ps

module sfm_acc_lane import sfm_acc_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    clear_i,
    input  logic    add_en_i,
    input  logic    scale_en_i,
    input  acc_t    addend_i,
    input  addend_t factor_i,
    output acc_t    sum_o
);

    logic [ACC_W+ADD_W-1:0] scale_prod;
    acc_t                   scaled;
    acc_t                   sum_d;

    // Truncated product, back to Q8.16
    assign scale_prod = sum_o * factor_i;
    assign scaled     = scale_en_i ? scale_prod[ADD_FRAC +: ACC_W] : sum_o;
    assign sum_d      = scaled + (add_en_i ? addend_i : '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sum_o <= '0;
        end else if (clear_i) begin
            sum_o <= '0;
        end else if (add_en_i | scale_en_i) begin
            sum_o <= sum_d;
        end
    end

endmodule

// ==== sfm_lane_reduce.sv ====
/*
 * Lane reducer
 * Adds one lane partial sum per cycle into the denominator register
 * and flags completion after the last lane
 */

`timescale 1ns/1ps

module sfm_lane_reduce import sfm_acc_pkg::*; #(
    parameter int unsigned N_LANES = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               clear_i,
    input  logic               start_i,
    input  acc_t [N_LANES-1:0] lane_sums_i,
    output logic               done_o,
    output acc_t               den_o
);

    localparam int unsigned IDX_W = $clog2(N_LANES);

    logic             busy_q;
    logic [IDX_W-1:0] idx_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
            done_o <= 1'b0;
            den_o  <= '0;
        end else if (clear_i) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
            done_o <= 1'b0;
            den_o  <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                idx_q  <= '0;
                den_o  <= '0;
            end else if (busy_q) begin
                // Plain wrapping sum
                den_o <= den_o + lane_sums_i[idx_q];
                if (idx_q == IDX_W'(N_LANES - 1)) begin
                    busy_q <= 1'b0;
                    done_o <= 1'b1;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

endmodule

// ==== sfm_recip_newton.sv ====
/*
 * Reciprocal of the denominator
 * Leading-one seed followed by Newton-Raphson iterations,
 * each split into an error-product cycle and an update cycle
 */

`timescale 1ns/1ps

module sfm_recip_newton import sfm_acc_pkg::*; #(
    parameter int unsigned N_INV_ITERS = 2
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic clear_i,
    input  logic start_i,
    input  acc_t den_i,
    output logic done_o,
    output acc_t recip_o
);

    localparam int unsigned ITER_W = $clog2(N_INV_ITERS + 1);
    localparam int unsigned INT_W  = ACC_W - ACC_FRAC;

    logic              busy_q;
    logic              upd_step_q;
    logic [ITER_W-1:0] iter_q;
    acc_t              err_q;
    acc_t              seed;
    logic [2*ACC_W-1:0] err_prod;
    logic [2*ACC_W-1:0] upd_prod;
    acc_t              two_minus_err;

    // Seed is 2^-p for the top set bit p of the integer part
    always_comb begin
        seed = acc_t'(1) << ACC_FRAC;
        for (int b = 0; b < INT_W; b++) begin
            if (den_i[ACC_FRAC + b]) begin
                seed = acc_t'(1) << (ACC_FRAC - b);
            end
        end
    end

    assign err_prod      = den_i * recip_o;
    assign two_minus_err = ACC_TWO - err_q;
    assign upd_prod      = recip_o * two_minus_err;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q     <= 1'b0;
            upd_step_q <= 1'b0;
            iter_q     <= '0;
            done_o     <= 1'b0;
            recip_o    <= '0;
        end else if (clear_i) begin
            busy_q     <= 1'b0;
            upd_step_q <= 1'b0;
            iter_q     <= '0;
            done_o     <= 1'b0;
            recip_o    <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_q     <= 1'b1;
                upd_step_q <= 1'b0;
                iter_q     <= '0;
                recip_o    <= seed;
            end else if (busy_q) begin
                upd_step_q <= ~upd_step_q;
                if (upd_step_q) begin
                    recip_o <= upd_prod[ACC_FRAC +: ACC_W];
                    if (iter_q == ITER_W'(N_INV_ITERS - 1)) begin
                        busy_q <= 1'b0;
                        done_o <= 1'b1;
                    end else begin
                        iter_q <= iter_q + 1'b1;
                    end
                end
            end
        end
    end

    // Error term e = den * x
    always_ff @(posedge clk_i) begin
        if (busy_q && !upd_step_q) begin
            err_q <= err_prod[ACC_FRAC +: ACC_W];
        end
    end

endmodule

// ==== sfm_acc_ctrl.sv ====
/*
 * Phase controller for the softmax denominator unit
 * Accumulate, reduce and invert sequencing with status outputs
 */

`timescale 1ns/1ps

module sfm_acc_ctrl import sfm_acc_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic clear_i,
    input  logic add_valid_i,
    input  logic acc_finished_i,
    input  logic acc_only_i,
    input  logic red_done_i,
    input  logic inv_done_i,
    output logic accept_en_o,
    output logic red_start_o,
    output logic inv_start_o,
    output logic valid_o,
    output logic acc_done_o,
    output logic reducing_o
);

    acc_state_e state_q;
    acc_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (add_valid_i) begin
                    state_d = COMPUTING;
                end
            end
            COMPUTING: begin
                if (acc_finished_i) begin
                    state_d = REDUCTION;
                end
            end
            REDUCTION: begin
                if (red_done_i) begin
                    state_d = acc_only_i ? IDLE : INVERSION;
                end
            end
            INVERSION: begin
                if (inv_done_i) begin
                    state_d = FINISHED;
                end
            end
            FINISHED: begin
                // A new addend restarts accumulation on top of the lane sums
                if (add_valid_i) begin
                    state_d = COMPUTING;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            red_start_o <= 1'b0;
        end else if (clear_i) begin
            state_q     <= IDLE;
            red_start_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            red_start_o <= (state_q == COMPUTING) & acc_finished_i;
        end
    end

    assign accept_en_o = (state_q != REDUCTION) & (state_q != INVERSION);
    assign reducing_o  = (state_q == REDUCTION);
    assign acc_done_o  = reducing_o & red_done_i;
    assign inv_start_o = acc_done_o & ~acc_only_i;
    assign valid_o     = (state_q == FINISHED);

endmodule

// ==== sfm_accumulator.sv ====
/*
 * Softmax denominator unit, top level
 * Controller, input dispatcher, partial-sum lanes, lane reducer
 * and Newton-Raphson reciprocal
 */

`timescale 1ns/1ps

module sfm_accumulator import sfm_acc_pkg::*; #(
    parameter int unsigned N_LANES     = 4,
    parameter int unsigned N_INV_ITERS = 2
) (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    clear_i,
    input  logic    add_valid_i,
    input  addend_t add_i,
    input  logic    mul_valid_i,
    input  addend_t mul_i,
    input  logic    acc_finished_i,
    input  logic    acc_only_i,
    output logic    ready_o,
    output logic    valid_o,
    output logic    acc_done_o,
    output logic    reducing_o,
    output acc_t    den_o,
    output acc_t    acc_o
);

    logic               accept_en;
    logic               red_start;
    logic               red_done;
    logic               inv_start;
    logic               inv_done;
    logic [N_LANES-1:0] add_en;
    logic               scale_en;
    acc_t               addend;
    addend_t            factor;
    acc_t [N_LANES-1:0] lane_sums;

    sfm_acc_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .clear_i        (clear_i),
        .add_valid_i    (add_valid_i),
        .acc_finished_i (acc_finished_i),
        .acc_only_i     (acc_only_i),
        .red_done_i     (red_done),
        .inv_done_i     (inv_done),
        .accept_en_o    (accept_en),
        .red_start_o    (red_start),
        .inv_start_o    (inv_start),
        .valid_o        (valid_o),
        .acc_done_o     (acc_done_o),
        .reducing_o     (reducing_o)
    );

    sfm_lane_dispatch #(
        .N_LANES (N_LANES)
    ) u_dispatch (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .accept_en_i (accept_en),
        .add_valid_i (add_valid_i),
        .add_i       (add_i),
        .mul_valid_i (mul_valid_i),
        .mul_i       (mul_i),
        .ready_o     (ready_o),
        .add_en_o    (add_en),
        .scale_en_o  (scale_en),
        .addend_o    (addend),
        .factor_o    (factor)
    );

    for (genvar i = 0; i < N_LANES; i++) begin : gen_lanes
        sfm_acc_lane u_lane (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .clear_i    (clear_i),
            .add_en_i   (add_en[i]),
            .scale_en_i (scale_en),
            .addend_i   (addend),
            .factor_i   (factor),
            .sum_o      (lane_sums[i])
        );
    end

    sfm_lane_reduce #(
        .N_LANES (N_LANES)
    ) u_reduce (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .start_i     (red_start),
        .lane_sums_i (lane_sums),
        .done_o      (red_done),
        .den_o       (den_o)
    );

    sfm_recip_newton #(
        .N_INV_ITERS (N_INV_ITERS)
    ) u_recip (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .start_i (inv_start),
        .den_i   (den_o),
        .done_o  (inv_done),
        .recip_o (acc_o)
    );

endmodule

// ==== sfm_accumulator_asserts.sv ====
/*
 * Concurrent assertions on the softmax denominator unit ports
 * Done pulse width, ready and valid coverage, ready low while reducing
 */

`timescale 1ns/1ps

module sfm_accumulator_asserts (
    input logic clk_i,
    input logic rst_ni,
    input logic clear_i,
    input logic acc_only_i,
    input logic ready_i,
    input logic valid_i,
    input logic acc_done_i,
    input logic reducing_i
);

    // High while the reciprocal is being computed
    logic inverting_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            inverting_q <= 1'b0;
        end else if (clear_i || valid_i) begin
            inverting_q <= 1'b0;
        end else if (acc_done_i && !acc_only_i) begin
            inverting_q <= 1'b1;
        end
    end

    done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        acc_done_i |=> !acc_done_i)
        else $error("acc_done_o stayed high for more than one cycle");

    ready_or_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!ready_i && !valid_i) |-> (reducing_i || inverting_q))
        else $error("ready_o and valid_o both low outside reduction and inversion");

    reduce_not_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        reducing_i |-> !ready_i)
        else $error("ready_o high while reducing_o is high");

endmodule

bind sfm_accumulator sfm_accumulator_asserts u_asserts (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .acc_only_i (acc_only_i),
    .ready_i    (ready_o),
    .valid_i    (valid_o),
    .acc_done_i (acc_done_o),
    .reducing_i (reducing_o)
);

// ==== tb_sfm_accumulator.sv ====
/*
 * Testbench for the softmax denominator unit
 * Run table with a fixed-point reference model, latency and value checks,
 * back-pressure during reduction and clear between runs
 */

`timescale 1ns/1ps

module tb_sfm_accumulator import sfm_acc_pkg::*; ();

    localparam int N_LANES            = 4;
    localparam int N_INV_ITERS        = 2;
    localparam int N_RUNS             = 5;
    localparam int MAX_STEPS          = 10;
    localparam int TIMEOUT_CYCLES     = 100;
    localparam int unsigned RAND_SEED = 69988;

    // Q8.16 constants for the reference model
    localparam acc_t ONE_Q16 = 24'h01_0000;
    localparam acc_t TWO_Q16 = 24'h02_0000;

    logic    clk_i;
    logic    rst_ni;
    logic    clear_i;
    logic    add_valid_i;
    addend_t add_i;
    logic    mul_valid_i;
    addend_t mul_i;
    logic    acc_finished_i;
    logic    acc_only_i;
    logic    ready_o;
    logic    valid_o;
    logic    acc_done_o;
    logic    reducing_o;
    acc_t    den_o;
    acc_t    acc_o;

    // Run table with one row of steps per run
    logic    step_add_v   [N_RUNS][MAX_STEPS];
    addend_t step_add     [N_RUNS][MAX_STEPS];
    logic    step_mul_v   [N_RUNS][MAX_STEPS];
    addend_t step_mul     [N_RUNS][MAX_STEPS];
    int      run_len      [N_RUNS];
    logic    run_acc_only [N_RUNS];
    logic    run_bp       [N_RUNS];
    acc_t    exp_den      [N_RUNS];
    acc_t    exp_recip    [N_RUNS];

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    sfm_accumulator #(
        .N_LANES     (N_LANES),
        .N_INV_ITERS (N_INV_ITERS)
    ) u_dut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .clear_i        (clear_i),
        .add_valid_i    (add_valid_i),
        .add_i          (add_i),
        .mul_valid_i    (mul_valid_i),
        .mul_i          (mul_i),
        .acc_finished_i (acc_finished_i),
        .acc_only_i     (acc_only_i),
        .ready_o        (ready_o),
        .valid_o        (valid_o),
        .acc_done_o     (acc_done_o),
        .reducing_o     (reducing_o),
        .den_o          (den_o),
        .acc_o          (acc_o)
    );

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout after %0d cycles while waiting for %s", TIMEOUT_CYCLES, what);
        $display("Test failed");
        $fatal(1, "Stopping after a timeout");
    endtask

    function automatic void add_step(input int r, input logic av, input addend_t a,
                                     input logic mv, input addend_t m);
        step_add_v[r][run_len[r]] = av;
        step_add[r][run_len[r]]   = a;
        step_mul_v[r][run_len[r]] = mv;
        step_mul[r][run_len[r]]   = m;
        run_len[r]++;
    endfunction

    // Truncated rescale before adding the addend aligned to Q8.16
    function automatic acc_t next_lane_sum(input acc_t sum, input logic scale,
                                           input addend_t factor, input logic add,
                                           input addend_t addend);
        logic [63:0] nxt;
        nxt = 64'(sum);
        if (scale) begin
            nxt = ((64'(sum) * 64'(factor)) >> ADD_FRAC) & 64'hFF_FFFF;
        end
        if (add) begin
            nxt = nxt + (64'(addend) << 1);
        end
        return acc_t'(nxt);
    endfunction

    function automatic void compute_expected(input int r);
        acc_t        lanes [N_LANES];
        acc_t        den;
        acc_t        x;
        acc_t        e;
        logic [63:0] prod;
        int          k;
        int          p;

        k = 0;
        for (int i = 0; i < N_LANES; i++) begin
            lanes[i] = '0;
        end
        for (int s = 0; s < run_len[r]; s++) begin
            for (int i = 0; i < N_LANES; i++) begin
                lanes[i] = next_lane_sum(lanes[i], step_mul_v[r][s], step_mul[r][s],
                                         step_add_v[r][s] && (i == k % N_LANES),
                                         step_add[r][s]);
            end
            if (step_add_v[r][s]) begin
                k++;
            end
        end
        den = '0;
        for (int i = 0; i < N_LANES; i++) begin
            den = den + lanes[i];
        end
        // Seed is 2^-p from the top set bit of the integer part
        p = 0;
        for (int b = 0; b < ACC_W - ACC_FRAC; b++) begin
            if (den[ACC_FRAC + b]) begin
                p = b;
            end
        end
        x = ONE_Q16 >> p;
        for (int it = 0; it < N_INV_ITERS; it++) begin
            prod = 64'(den) * 64'(x);
            e    = acc_t'(prod >> ACC_FRAC);
            prod = 64'(x) * 64'(acc_t'(TWO_Q16 - e));
            x    = acc_t'(prod >> ACC_FRAC);
        end
        exp_den[r]   = den;
        exp_recip[r] = run_acc_only[r] ? '0 : x;
    endfunction

    task automatic build_table();
        for (int r = 0; r < N_RUNS; r++) begin
            run_len[r] = 0;
        end

        // Plain accumulation with reduction only
        run_acc_only[0] = 1'b1;
        run_bp[0]       = 1'b0;
        add_step(0, 1'b1, 16'h8000, 1'b0, 16'h0000);
        add_step(0, 1'b1, 16'h4000, 1'b0, 16'h0000);
        add_step(0, 1'b1, 16'hC000, 1'b0, 16'h0000);
        add_step(0, 1'b1, 16'h2000, 1'b0, 16'h0000);
        add_step(0, 1'b1, 16'h7FFF, 1'b0, 16'h0000);
        add_step(0, 1'b1, 16'h0001, 1'b0, 16'h0000);

        // Rescaling with a factor and an addend in the same cycle
        run_acc_only[1] = 1'b1;
        run_bp[1]       = 1'b0;
        add_step(1, 1'b1, 16'h9000, 1'b0, 16'h0000);
        add_step(1, 1'b1, 16'h5555, 1'b0, 16'h0000);
        add_step(1, 1'b0, 16'h0000, 1'b1, 16'h6000);
        add_step(1, 1'b1, 16'h3333, 1'b1, 16'h7000);
        add_step(1, 1'b1, 16'hFFFF, 1'b0, 16'h0000);
        add_step(1, 1'b0, 16'h0000, 1'b1, 16'h4001);
        add_step(1, 1'b1, 16'h1234, 1'b0, 16'h0000);
        add_step(1, 1'b1, 16'hABCD, 1'b0, 16'h0000);

        // Random addends and one factor followed by the reciprocal
        run_acc_only[2] = 1'b0;
        run_bp[2]       = 1'b0;
        for (int s = 0; s < 8; s++) begin
            add_step(2, 1'b1, addend_t'($urandom_range(32'hFFFF, 32'h4000)),
                     (s == 4), 16'h7800);
        end

        // Addends offered during reduction must be dropped
        run_acc_only[3] = 1'b0;
        run_bp[3]       = 1'b1;
        for (int s = 0; s < 5; s++) begin
            add_step(3, 1'b1, addend_t'($urandom_range(32'hFFFF, 32'h4000)),
                     1'b0, 16'h0000);
        end

        // Fresh run after clear with exact and fractional factors
        run_acc_only[4] = 1'b0;
        run_bp[4]       = 1'b0;
        add_step(4, 1'b1, 16'hE000, 1'b0, 16'h0000);
        add_step(4, 1'b1, 16'h6000, 1'b1, 16'h8000);
        add_step(4, 1'b1, 16'h1000, 1'b0, 16'h0000);
        add_step(4, 1'b0, 16'h0000, 1'b1, 16'h5000);
        add_step(4, 1'b1, 16'hF00F, 1'b0, 16'h0000);

        for (int r = 0; r < N_RUNS; r++) begin
            compute_expected(r);
        end
    endtask

    task automatic clear_dut();
        clear_i = 1'b1;
        @(posedge clk_i);
        #1;
        clear_i = 1'b0;
        check_value(64'(den_o), 64'd0, "den_o after clear");
        check_value(64'(acc_o), 64'd0, "acc_o after clear");
        check_value(64'(valid_o), 64'd0, "valid_o after clear");
        check_value(64'(ready_o), 64'd1, "ready_o after clear");
        check_value(64'(reducing_o), 64'd0, "reducing_o after clear");
    endtask

    task automatic apply_run(input int r);
        int   cycles;
        logic seen;

        acc_only_i = run_acc_only[r];
        for (int s = 0; s < run_len[r]; s++) begin
            check_value(64'(ready_o), 64'd1, $sformatf("run %0d ready_o at step %0d", r, s));
            add_valid_i = step_add_v[r][s];
            add_i       = step_add[r][s];
            mul_valid_i = step_mul_v[r][s];
            mul_i       = step_mul[r][s];
            @(posedge clk_i);
            #1;
        end
        add_valid_i    = 1'b0;
        mul_valid_i    = 1'b0;
        acc_finished_i = 1'b1;

        // Back-pressure runs keep offering addends while reducing
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clk_i);
            #1;
            cycles++;
            acc_finished_i = 1'b0;
            if (acc_done_o) begin
                seen = 1'b1;
            end else if (cycles >= TIMEOUT_CYCLES) begin
                report_timeout("acc_done_o");
            end
            if (reducing_o) begin
                check_value(64'(ready_o), 64'd0, $sformatf("run %0d ready_o while reducing", r));
            end
            add_valid_i = run_bp[r] & reducing_o & ~acc_done_o;
            add_i       = addend_t'($urandom());
        end
        check_value(64'(cycles), 64'(N_LANES + 2), $sformatf("run %0d reduce latency", r));
        check_value(64'(den_o), 64'(exp_den[r]), $sformatf("run %0d den_o", r));

        if (run_acc_only[r]) begin
            repeat (2 * N_INV_ITERS + 3) begin
                @(posedge clk_i);
                #1;
                check_value(64'(valid_o), 64'd0, $sformatf("run %0d valid_o", r));
            end
            check_value(64'(acc_o), 64'd0, $sformatf("run %0d acc_o", r));
        end else begin
            cycles = 0;
            seen   = 1'b0;
            while (!seen) begin
                @(posedge clk_i);
                #1;
                cycles++;
                if (valid_o) begin
                    seen = 1'b1;
                end else if (cycles >= TIMEOUT_CYCLES) begin
                    report_timeout("valid_o");
                end
            end
            check_value(64'(cycles), 64'(2 * N_INV_ITERS + 2),
                        $sformatf("run %0d invert latency", r));
            check_value(64'(acc_o), 64'(exp_recip[r]), $sformatf("run %0d acc_o", r));
            check_value(64'(ready_o), 64'd1, $sformatf("run %0d ready_o when valid", r));
        end
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        rst_ni         = 1'b0;
        clear_i        = 1'b0;
        add_valid_i    = 1'b0;
        add_i          = '0;
        mul_valid_i    = 1'b0;
        mul_i          = '0;
        acc_finished_i = 1'b0;
        acc_only_i     = 1'b0;
        build_table();

        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_value(64'(ready_o), 64'd1, "ready_o after reset");
        check_value(64'(valid_o), 64'd0, "valid_o after reset");
        check_value(64'(acc_done_o), 64'd0, "acc_done_o after reset");
        check_value(64'(reducing_o), 64'd0, "reducing_o after reset");
        check_value(64'(den_o), 64'd0, "den_o after reset");
        check_value(64'(acc_o), 64'd0, "acc_o after reset");

        for (int r = 0; r < N_RUNS; r++) begin
            clear_dut();
            apply_run(r);
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== sfm_accumulator.f ====
sfm_acc_pkg.sv
sfm_lane_dispatch.sv
sfm_acc_lane.sv
sfm_lane_reduce.sv
sfm_recip_newton.sv
sfm_acc_ctrl.sv
sfm_accumulator.sv
sfm_accumulator_asserts.sv
tb_sfm_accumulator.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_sfm_accumulator
FILELIST := sfm_accumulator.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -qx "Test passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
